// ==== logic/csr_consts.svh ====
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// CSR addresses
`define CSR_CRMD            14'h000
`define CSR_PRMD            14'h001
`define CSR_ECFG            14'h004
`define CSR_ESTAT           14'h005
`define CSR_ERA             14'h006
`define CSR_BADV            14'h007
`define CSR_EENTRY          14'h00C
`define CSR_SAVE0           14'h030
`define CSR_SAVE1           14'h031
`define CSR_SAVE2           14'h032
`define CSR_SAVE3           14'h033
`define CSR_TID             14'h040
`define CSR_TCFG            14'h041
`define CSR_TVAL            14'h042
`define CSR_TICLR           14'h044

`define CSR_SAVE_NUM        4       // SAVE0..SAVE3 at consecutive addresses

// Exception codes
`define ECODE_ADE           6'h08
`define ECODE_ALE           6'h09
`define ESUBCODE_ADEF       9'h000  // ADE from instruction fetch

`define CRMD_RESET          32'h0000_0008   // DA set, PLV0, IE off

// Software write masks
`define CRMD_WMASK          32'h0000_01FF
`define PRMD_WMASK          32'h0000_0007
`define ECFG_WMASK          32'h0000_1BFF   // LIE 9:0 and 12:11
`define ESTAT_WMASK         32'h0000_0003   // SWI only
`define EENTRY_WMASK        32'hFFFF_FFC0

// Field positions
`define CRMD_IE_BIT         2
`define ESTAT_TI_BIT        11
`define ESTAT_HWI_LSB       2
`define ECODE_LSB           16
`define ESUBCODE_LSB        22
`define TCFG_EN_BIT         0
`define TCFG_PERIODIC_BIT   1
`define TICLR_CLR_BIT       0

`endif

// ==== logic/csr_pkg.sv ====
package csr_pkg;

    // CSR number as carried by csrrd/csrwr/csrxchg
    typedef logic [13:0] csr_addr_t;

    typedef logic [31:0] csr_word_t;

    typedef logic [5:0]  ecode_t;     // ESTAT.Ecode
    typedef logic [8:0]  esubcode_t;  // ESTAT.EsubCode

    // PLV0 is kernel, PLV3 is user
    typedef logic [1:0]  plv_t;

endpackage

// ==== logic/csr_exception_regs.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_exception_regs
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      csr_write_en,
    input  csr_addr_t csr_write_addr,
    input  csr_word_t csr_write_data,

    input  logic      is_exception,
    input  logic      is_ertn,
    input  csr_word_t exception_pc,
    input  csr_word_t exception_addr,
    input  ecode_t    ecode,
    input  esubcode_t esubcode,

    input  logic [7:0] hwi,
    input  logic      ti_pending,

    output csr_word_t crmd,
    output csr_word_t prmd,
    output csr_word_t ecfg,
    output csr_word_t estat,
    output csr_word_t era,
    output csr_word_t badv,
    output csr_word_t eentry
);

    logic      crmd_wen;
    logic      prmd_wen;
    logic      ecfg_wen;
    logic      estat_wen;
    logic      era_wen;
    logic      badv_wen;
    logic      eentry_wen;
    csr_word_t estat_q;     // Everything but TI
    plv_t      cur_plv;
    logic      cur_ie;

    function automatic csr_word_t masked_write(input csr_word_t old_val,
                                               input csr_word_t new_val,
                                               input csr_word_t mask);
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    assign crmd_wen   = csr_write_en && (csr_write_addr == `CSR_CRMD);
    assign prmd_wen   = csr_write_en && (csr_write_addr == `CSR_PRMD);
    assign ecfg_wen   = csr_write_en && (csr_write_addr == `CSR_ECFG);
    assign estat_wen  = csr_write_en && (csr_write_addr == `CSR_ESTAT);
    assign era_wen    = csr_write_en && (csr_write_addr == `CSR_ERA);
    assign badv_wen   = csr_write_en && (csr_write_addr == `CSR_BADV);
    assign eentry_wen = csr_write_en && (csr_write_addr == `CSR_EENTRY);

    assign cur_plv = crmd[1:0];
    assign cur_ie  = crmd[`CRMD_IE_BIT];

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd <= `CRMD_RESET;
        end else if (is_exception) begin
            crmd[1:0]          <= '0;   // Enter kernel
            crmd[`CRMD_IE_BIT] <= 1'b0;
        end else if (is_ertn) begin
            crmd[1:0]          <= prmd[1:0];
            crmd[`CRMD_IE_BIT] <= prmd[`CRMD_IE_BIT];
        end else if (crmd_wen) begin
            crmd <= masked_write(crmd, csr_write_data, `CRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prmd <= '0;
        end else if (is_exception) begin
            prmd[1:0]          <= cur_plv;  // PPLV
            prmd[`CRMD_IE_BIT] <= cur_ie;   // PIE
        end else if (prmd_wen) begin
            prmd <= masked_write(prmd, csr_write_data, `PRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ecfg <= '0;
        end else if (ecfg_wen) begin
            ecfg <= masked_write(ecfg, csr_write_data, `ECFG_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            estat_q <= '0;
        end else begin
            if (is_exception) begin
                estat_q[`ECODE_LSB +: $bits(ecode_t)]       <= ecode;
                estat_q[`ESUBCODE_LSB +: $bits(esubcode_t)] <= esubcode;
            end else if (estat_wen) begin
                estat_q <= masked_write(estat_q, csr_write_data, `ESTAT_WMASK);
            end
            estat_q[`ESTAT_HWI_LSB +: 8] <= hwi;   // Sampled every cycle
        end
    end

    // Timer interrupt lives in the timer block
    always_comb begin
        estat                = estat_q;
        estat[`ESTAT_TI_BIT] = ti_pending;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            era <= '0;
        end else if (is_exception) begin
            era <= exception_pc;
        end else if (era_wen) begin
            era <= csr_write_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            badv <= '0;
        end else if (is_exception) begin
            if (ecode == `ECODE_ALE) begin
                badv <= exception_addr;
            end else if (ecode == `ECODE_ADE && esubcode == `ESUBCODE_ADEF) begin
                badv <= exception_pc;   // Bad fetch address is the pc itself
            end
        end else if (badv_wen) begin
            badv <= csr_write_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            eentry <= '0;
        end else if (eentry_wen) begin
            eentry <= masked_write(eentry, csr_write_data, `EENTRY_WMASK);
        end
    end

    // Control unit must never raise both in one cycle
    excp_ertn_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(is_exception && is_ertn)
    ) else $error("is_exception and is_ertn high together");

endmodule

// ==== logic/csr_timer.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_timer
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      csr_write_en,
    input  csr_addr_t csr_write_addr,
    input  csr_word_t csr_write_data,

    output csr_word_t tcfg,
    output csr_word_t tval,
    output logic      ti_pending
);

    logic      tcfg_wen;
    logic      ticlr_wen;
    logic      timer_en;
    logic      expire;
    csr_word_t init_val;

    assign tcfg_wen  = csr_write_en && (csr_write_addr == `CSR_TCFG);
    assign ticlr_wen = csr_write_en && (csr_write_addr == `CSR_TICLR);

    assign init_val = {tcfg[31:2], 2'b00};   // InitVal field, low bits zero
    assign expire   = timer_en && (tval == '0) && !tcfg_wen;

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg <= '0;
        end else if (tcfg_wen) begin
            tcfg <= csr_write_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tval     <= '0;
            timer_en <= 1'b0;
        end else if (tcfg_wen) begin
            tval     <= {csr_write_data[31:2], 2'b00};
            timer_en <= csr_write_data[`TCFG_EN_BIT];
        end else if (timer_en) begin
            if (tval != '0) begin
                tval <= tval - 32'd1;
            end else if (tcfg[`TCFG_PERIODIC_BIT]) begin
                tval <= init_val;   // Periodic reload
            end else begin
                tval     <= '1;     // One-shot parks at all ones
                timer_en <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ti_pending <= 1'b0;
        end else if (ticlr_wen && csr_write_data[`TICLR_CLR_BIT]) begin
            ti_pending <= 1'b0;     // Clear wins over a new expiry
        end else if (expire) begin
            ti_pending <= 1'b1;
        end
    end

    // Counter is frozen unless running or reloaded by software
    tval_frozen_when_idle: assert property (
        @(posedge clk) disable iff (rst) (!timer_en && !tcfg_wen) |=> $stable(tval)
    ) else $error("tval moved while timer disabled");

endmodule

// ==== logic/csr_save_regs.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_save_regs
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      csr_write_en,
    input  csr_addr_t csr_write_addr,
    input  csr_word_t csr_write_data,

    output csr_word_t save0,
    output csr_word_t save1,
    output csr_word_t save2,
    output csr_word_t save3,
    output csr_word_t tid
);

    csr_word_t save_q [`CSR_SAVE_NUM];

    // SAVEn sit at consecutive CSR numbers
    always_ff @(posedge clk) begin
        for (int i = 0; i < `CSR_SAVE_NUM; i++) begin
            if (rst) begin
                save_q[i] <= '0;
            end else if (csr_write_en &&
                         csr_write_addr == csr_addr_t'(`CSR_SAVE0 + i)) begin
                save_q[i] <= csr_write_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tid <= '0;
        end else if (csr_write_en && csr_write_addr == `CSR_TID) begin
            tid <= csr_write_data;
        end
    end

    assign save0 = save_q[0];
    assign save1 = save_q[1];
    assign save2 = save_q[2];
    assign save3 = save_q[3];

endmodule

// ==== logic/csr_read_mux.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_read_mux
    import csr_pkg::*;
(
    input  logic            rst,
    input  logic      [1:0] csr_read_en,
    input  csr_addr_t [1:0] csr_read_addr,

    input  csr_word_t       crmd,
    input  csr_word_t       prmd,
    input  csr_word_t       ecfg,
    input  csr_word_t       estat,
    input  csr_word_t       era,
    input  csr_word_t       badv,
    input  csr_word_t       eentry,
    input  csr_word_t       save0,
    input  csr_word_t       save1,
    input  csr_word_t       save2,
    input  csr_word_t       save3,
    input  csr_word_t       tid,
    input  csr_word_t       tcfg,
    input  csr_word_t       tval,

    output csr_word_t [1:0] csr_read_data
);

    // Same select for both dispatch ports
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            csr_read_data[i] = '0;
            if (!rst && csr_read_en[i]) begin
                case (csr_read_addr[i])
                    `CSR_CRMD:   csr_read_data[i] = crmd;
                    `CSR_PRMD:   csr_read_data[i] = prmd;
                    `CSR_ECFG:   csr_read_data[i] = ecfg;
                    `CSR_ESTAT:  csr_read_data[i] = estat;
                    `CSR_ERA:    csr_read_data[i] = era;
                    `CSR_BADV:   csr_read_data[i] = badv;
                    `CSR_EENTRY: csr_read_data[i] = eentry;
                    `CSR_SAVE0:  csr_read_data[i] = save0;
                    `CSR_SAVE1:  csr_read_data[i] = save1;
                    `CSR_SAVE2:  csr_read_data[i] = save2;
                    `CSR_SAVE3:  csr_read_data[i] = save3;
                    `CSR_TID:    csr_read_data[i] = tid;
                    `CSR_TCFG:   csr_read_data[i] = tcfg;
                    `CSR_TVAL:   csr_read_data[i] = tval;
                    `CSR_TICLR:  csr_read_data[i] = '0;   // Write-only
                    default:     csr_read_data[i] = '0;
                endcase
            end
        end
    end

endmodule

// ==== logic/csr_top.sv ====
`timescale 1ns/1ps

module csr_top
    import csr_pkg::*;
(
    input  logic            clk,
    input  logic            rst,

    // From writeback
    input  logic            csr_write_en,
    input  csr_addr_t       csr_write_addr,
    input  csr_word_t       csr_write_data,

    // From control unit
    input  logic            is_exception,
    input  logic            is_ertn,
    input  csr_word_t       exception_pc,
    input  csr_word_t       exception_addr,
    input  ecode_t          ecode,
    input  esubcode_t       esubcode,

    input  logic      [7:0] hwi,

    // Dispatch read ports
    input  logic      [1:0] csr_read_en,
    input  csr_addr_t [1:0] csr_read_addr,
    output csr_word_t [1:0] csr_read_data,

    // To control unit
    output csr_word_t       crmd,
    output csr_word_t       ecfg,
    output csr_word_t       estat,
    output csr_word_t       era,
    output csr_word_t       eentry
);

    csr_word_t prmd;
    csr_word_t badv;
    csr_word_t tcfg;
    csr_word_t tval;
    logic      ti_pending;
    csr_word_t save0;
    csr_word_t save1;
    csr_word_t save2;
    csr_word_t save3;
    csr_word_t tid;

    csr_exception_regs u_exception_regs (
        .clk            (clk),
        .rst            (rst),
        .csr_write_en   (csr_write_en),
        .csr_write_addr (csr_write_addr),
        .csr_write_data (csr_write_data),
        .is_exception   (is_exception),
        .is_ertn        (is_ertn),
        .exception_pc   (exception_pc),
        .exception_addr (exception_addr),
        .ecode          (ecode),
        .esubcode       (esubcode),
        .hwi            (hwi),
        .ti_pending     (ti_pending),
        .crmd           (crmd),
        .prmd           (prmd),
        .ecfg           (ecfg),
        .estat          (estat),
        .era            (era),
        .badv           (badv),
        .eentry         (eentry)
    );

    csr_timer u_timer (
        .clk            (clk),
        .rst            (rst),
        .csr_write_en   (csr_write_en),
        .csr_write_addr (csr_write_addr),
        .csr_write_data (csr_write_data),
        .tcfg           (tcfg),
        .tval           (tval),
        .ti_pending     (ti_pending)
    );

    csr_save_regs u_save_regs (
        .clk            (clk),
        .rst            (rst),
        .csr_write_en   (csr_write_en),
        .csr_write_addr (csr_write_addr),
        .csr_write_data (csr_write_data),
        .save0          (save0),
        .save1          (save1),
        .save2          (save2),
        .save3          (save3),
        .tid            (tid)
    );

    csr_read_mux u_read_mux (
        .rst            (rst),
        .csr_read_en    (csr_read_en),
        .csr_read_addr  (csr_read_addr),
        .crmd           (crmd),
        .prmd           (prmd),
        .ecfg           (ecfg),
        .estat          (estat),
        .era            (era),
        .badv           (badv),
        .eentry         (eentry),
        .save0          (save0),
        .save1          (save1),
        .save2          (save2),
        .save3          (save3),
        .tid            (tid),
        .tcfg           (tcfg),
        .tval           (tval),
        .csr_read_data  (csr_read_data)
    );

endmodule

// ==== testbench/tb_csr_top.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module tb_csr_top
    import csr_pkg::*;
();

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 16;
    localparam int TEST_CYCLES   = 15 + 66 + 20 + 24 + 26 + 72;   // Tests 1 to 6
    localparam int MARGIN_CYCLES = 60;
    localparam int WATCHDOG_NS   = (RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

    localparam csr_addr_t KEPT [15] = '{`CSR_CRMD, `CSR_PRMD, `CSR_ECFG, `CSR_ESTAT, `CSR_ERA,
        `CSR_BADV, `CSR_EENTRY, `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_TID,
        `CSR_TCFG, `CSR_TVAL, `CSR_TICLR};

    logic            clk;
    logic            rst;
    logic            csr_write_en;
    csr_addr_t       csr_write_addr;
    csr_word_t       csr_write_data;
    logic            is_exception;
    logic            is_ertn;
    csr_word_t       exception_pc;
    csr_word_t       exception_addr;
    ecode_t          ecode;
    esubcode_t       esubcode;
    logic      [7:0] hwi;
    logic      [1:0] csr_read_en;
    csr_addr_t [1:0] csr_read_addr;
    csr_word_t [1:0] csr_read_data;
    csr_word_t       crmd;
    csr_word_t       ecfg;
    csr_word_t       estat;
    csr_word_t       era;
    csr_word_t       eentry;

    // Reference model state
    csr_word_t sh_crmd, sh_prmd, sh_ecfg, sh_estat, sh_era, sh_badv, sh_eentry;
    csr_word_t sh_save0, sh_save1, sh_save2, sh_save3, sh_tid;
    csr_word_t sh_tcfg, sh_tval;
    logic      sh_ten, sh_ti;
    csr_word_t exp_estat;
    csr_word_t [1:0] exp_rd;

    int        err_count;
    int        errs_at_start;
    int        tests_passed;
    int        tests_failed;
    csr_word_t rng;

    csr_top u_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic csr_word_t xorshift32(input csr_word_t x);
        csr_word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function csr_word_t next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic wr_hit(input csr_addr_t addr);
        return csr_write_en && (csr_write_addr == addr);
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            sh_crmd   <= 32'h8;
            sh_prmd   <= '0;
            sh_ecfg   <= '0;
            sh_estat  <= '0;
            sh_era    <= '0;
            sh_badv   <= '0;
            sh_eentry <= '0;
            sh_save0  <= '0;
            sh_save1  <= '0;
            sh_save2  <= '0;
            sh_save3  <= '0;
            sh_tid    <= '0;
            sh_tcfg   <= '0;
            sh_tval   <= '0;
            sh_ten    <= 1'b0;
            sh_ti     <= 1'b0;
        end else begin
            if (is_exception) begin
                sh_crmd[2:0]    <= 3'b000;          // PLV0, IE off
                sh_prmd[2:0]    <= sh_crmd[2:0];
                sh_era          <= exception_pc;
                sh_estat[21:16] <= ecode;
                sh_estat[30:22] <= esubcode;
                if (ecode == `ECODE_ALE) begin
                    sh_badv <= exception_addr;
                end else if (ecode == `ECODE_ADE && esubcode == '0) begin
                    sh_badv <= exception_pc;
                end
            end else begin
                if (is_ertn) begin
                    sh_crmd[2:0] <= sh_prmd[2:0];
                end else if (wr_hit(`CSR_CRMD)) begin
                    sh_crmd[8:0] <= csr_write_data[8:0];
                end
                if (wr_hit(`CSR_PRMD)) sh_prmd[2:0] <= csr_write_data[2:0];
                if (wr_hit(`CSR_ESTAT)) sh_estat[1:0] <= csr_write_data[1:0];
                if (wr_hit(`CSR_ERA)) sh_era <= csr_write_data;
                if (wr_hit(`CSR_BADV)) sh_badv <= csr_write_data;
            end
            if (wr_hit(`CSR_ECFG)) begin
                sh_ecfg[9:0]   <= csr_write_data[9:0];
                sh_ecfg[12:11] <= csr_write_data[12:11];
            end
            if (wr_hit(`CSR_EENTRY)) sh_eentry[31:6] <= csr_write_data[31:6];
            if (wr_hit(`CSR_SAVE0)) sh_save0 <= csr_write_data;
            if (wr_hit(`CSR_SAVE1)) sh_save1 <= csr_write_data;
            if (wr_hit(`CSR_SAVE2)) sh_save2 <= csr_write_data;
            if (wr_hit(`CSR_SAVE3)) sh_save3 <= csr_write_data;
            if (wr_hit(`CSR_TID)) sh_tid <= csr_write_data;
            sh_estat[9:2] <= hwi;

            // Countdown rule
            if (wr_hit(`CSR_TCFG)) begin
                sh_tcfg <= csr_write_data;
                sh_tval <= csr_write_data & ~32'h3;
                sh_ten  <= csr_write_data[0];
            end else if (sh_ten && sh_tval != '0) begin
                sh_tval <= sh_tval - 1;
            end else if (sh_ten && sh_tcfg[1]) begin
                sh_tval <= sh_tcfg & ~32'h3;
            end else if (sh_ten) begin
                sh_tval <= 32'hFFFF_FFFF;
                sh_ten  <= 1'b0;
            end
            if (wr_hit(`CSR_TICLR) && csr_write_data[0]) begin
                sh_ti <= 1'b0;
            end else if (sh_ten && sh_tval == '0 && !wr_hit(`CSR_TCFG)) begin
                sh_ti <= 1'b1;
            end
        end
    end

    always_comb begin
        exp_estat     = sh_estat;
        exp_estat[11] = sh_ti;
        for (int p = 0; p < 2; p++) begin
            exp_rd[p] = '0;
            if (csr_read_en[p]) begin
                case (csr_read_addr[p])
                    `CSR_CRMD:   exp_rd[p] = sh_crmd;
                    `CSR_PRMD:   exp_rd[p] = sh_prmd;
                    `CSR_ECFG:   exp_rd[p] = sh_ecfg;
                    `CSR_ESTAT:  exp_rd[p] = exp_estat;
                    `CSR_ERA:    exp_rd[p] = sh_era;
                    `CSR_BADV:   exp_rd[p] = sh_badv;
                    `CSR_EENTRY: exp_rd[p] = sh_eentry;
                    `CSR_SAVE0:  exp_rd[p] = sh_save0;
                    `CSR_SAVE1:  exp_rd[p] = sh_save1;
                    `CSR_SAVE2:  exp_rd[p] = sh_save2;
                    `CSR_SAVE3:  exp_rd[p] = sh_save3;
                    `CSR_TID:    exp_rd[p] = sh_tid;
                    `CSR_TCFG:   exp_rd[p] = sh_tcfg;
                    `CSR_TVAL:   exp_rd[p] = sh_tval;
                    default:     exp_rd[p] = '0;
                endcase
            end
        end
    end

    task automatic report_mismatch(input string what, input csr_word_t got, input csr_word_t want);
        err_count++;
        $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, want);
    endtask

    read0_ok: assert property (@(posedge clk) disable iff (rst) csr_read_data[0] == exp_rd[0])
        else report_mismatch("read port 0", $sampled(csr_read_data[0]), $sampled(exp_rd[0]));
    read1_ok: assert property (@(posedge clk) disable iff (rst) csr_read_data[1] == exp_rd[1])
        else report_mismatch("read port 1", $sampled(csr_read_data[1]), $sampled(exp_rd[1]));
    reads_zero_in_reset: assert property (@(posedge clk) rst |-> csr_read_data == '0)
        else report_mismatch("read data in reset",
                             $sampled(csr_read_data[0] | csr_read_data[1]), '0);
    crmd_ok: assert property (@(posedge clk) disable iff (rst) crmd == sh_crmd)
        else report_mismatch("crmd", $sampled(crmd), $sampled(sh_crmd));
    ecfg_ok: assert property (@(posedge clk) disable iff (rst) ecfg == sh_ecfg)
        else report_mismatch("ecfg", $sampled(ecfg), $sampled(sh_ecfg));
    estat_ok: assert property (@(posedge clk) disable iff (rst) estat == exp_estat)
        else report_mismatch("estat", $sampled(estat), $sampled(exp_estat));
    era_ok: assert property (@(posedge clk) disable iff (rst) era == sh_era)
        else report_mismatch("era", $sampled(era), $sampled(sh_era));
    eentry_ok: assert property (@(posedge clk) disable iff (rst) eentry == sh_eentry)
        else report_mismatch("eentry", $sampled(eentry), $sampled(sh_eentry));

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_csr(input csr_addr_t addr, input csr_word_t data);
        csr_write_en   = 1'b1;
        csr_write_addr = addr;
        csr_write_data = data;
        next_cycle();
        csr_write_en   = 1'b0;
    endtask

    task automatic read_pair(input csr_addr_t a0, input csr_addr_t a1);
        csr_read_en      = 2'b11;
        csr_read_addr[0] = a0;
        csr_read_addr[1] = a1;
        next_cycle();
    endtask

    task automatic finish_test(input string name);
        if (err_count == errs_at_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", name, err_count - errs_at_start);
        end
        errs_at_start = err_count;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        rng = 32'h69eb78aa;
        err_count = 0;
        errs_at_start = 0;
        tests_passed = 0;
        tests_failed = 0;
        csr_write_en = 1'b0;
        csr_write_addr = '0;
        csr_write_data = '0;
        is_exception = 1'b0;
        is_ertn = 1'b0;
        exception_pc = '0;
        exception_addr = '0;
        ecode = '0;
        esubcode = '0;
        hwi = '0;
        csr_read_en = 2'b11;
        csr_read_addr[0] = `CSR_CRMD;      // CRMD resets to a nonzero value
        csr_read_addr[1] = `CSR_CRMD;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < 15; i++) read_pair(KEPT[i], KEPT[14 - i]);
        finish_test("1 reset values");

        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 15; i++) begin
                write_csr(KEPT[i], next_rand());
                read_pair(KEPT[i], KEPT[(i + 7) % 15]);
            end
        end
        read_pair(14'h3FF, `CSR_TICLR);     // Unknown address and write-only TICLR
        csr_read_addr[0] = `CSR_SAVE0;
        csr_read_addr[1] = `CSR_SAVE1;
        csr_read_en = 2'b10;
        next_cycle();
        csr_read_en = 2'b01;
        next_cycle();
        write_csr(`CSR_TCFG, '0);
        finish_test("2 masked writes and reads");

        for (int i = 0; i < 4; i++) begin
            write_csr(`CSR_CRMD, 32'h7);     // PLV3 with IE
            is_exception   = 1'b1;
            exception_pc   = next_rand();
            exception_addr = next_rand();
            ecode    = (i == 0) ? `ECODE_ALE : (i == 3) ? ecode_t'(next_rand()) : `ECODE_ADE;
            esubcode = (i == 1) ? '0 : esubcode_t'(next_rand());
            next_cycle();
            is_exception = 1'b0;
            read_pair(`CSR_PRMD, `CSR_BADV);
            read_pair(`CSR_CRMD, `CSR_ESTAT);
        end
        finish_test("3 exception entry");

        for (int i = 0; i < 4; i++) begin
            write_csr(`CSR_CRMD, next_rand());
            is_exception   = 1'b1;
            ecode          = `ECODE_ALE;
            csr_write_en   = 1'b1;          // Loses to the exception
            csr_write_addr = `CSR_CRMD;
            csr_write_data = next_rand();
            next_cycle();
            is_exception = 1'b0;
            csr_write_en = 1'b0;
            read_pair(`CSR_CRMD, `CSR_PRMD);
            write_csr(`CSR_PRMD, next_rand());
            is_ertn = 1'b1;
            next_cycle();
            is_ertn = 1'b0;
            read_pair(`CSR_CRMD, `CSR_PRMD);
        end
        finish_test("4 exception return");

        csr_read_en = 2'b11;
        csr_read_addr[0] = `CSR_ESTAT;
        csr_read_addr[1] = `CSR_ECFG;
        for (int i = 0; i < 24; i++) begin
            hwi = 8'(next_rand());
            csr_write_en = 1'b1;
            csr_write_addr = `CSR_ESTAT;
            csr_write_data = next_rand();
            next_cycle();
        end
        csr_write_en = 1'b0;
        hwi = '0;
        next_cycle();
        finish_test("5 hardware interrupt lines");

        write_csr(`CSR_TICLR, 32'h1);
        write_csr(`CSR_TCFG, 32'h15);       // One-shot, initial value 20
        for (int i = 0; i < 30; i++) read_pair(`CSR_TVAL, `CSR_ESTAT);
        write_csr(`CSR_TICLR, 32'h1);
        read_pair(`CSR_TVAL, `CSR_ESTAT);
        read_pair(`CSR_TCFG, `CSR_ESTAT);
        write_csr(`CSR_TCFG, 32'h0B);       // Periodic, initial value 8
        for (int i = 0; i < 30; i++) read_pair(`CSR_TVAL, `CSR_ESTAT);
        write_csr(`CSR_TICLR, 32'h1);
        write_csr(`CSR_TCFG, '0);
        for (int i = 0; i < 3; i++) read_pair(`CSR_TVAL, `CSR_ESTAT);
        finish_test("6 timer");

        $display("%0d tests ok, %0d tests failed, %0d mismatches",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/csr_pkg.sv
logic/csr_exception_regs.sv
logic/csr_timer.sv
logic/csr_save_regs.sv
logic/csr_read_mux.sv
logic/csr_top.sv
testbench/tb_csr_top.sv
